// File: flist.f
+incdir+design
design/isaPkg.sv
design/pipePkg.sv
design/fetchUnit.sv
design/stageReg.sv
design/decodeStage.sv
design/hazardUnit.sv
design/executeStage.sv
design/mipsCore.sv
testbench/writebackChecker.sv
testbench/tbMipsCore.sv

// File: Bender.yml
package:
  name: mips_core

sources:
  - include_dirs:
      - design
    files:
      - design/isaPkg.sv
      - design/pipePkg.sv
      - design/fetchUnit.sv
      - design/stageReg.sv
      - design/decodeStage.sv
      - design/hazardUnit.sv
      - design/executeStage.sv
      - design/mipsCore.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/writebackChecker.sv
      - testbench/tbMipsCore.sv

// File: testbench/tbMipsCore.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module tbMipsCore;
    localparam int PROG_LEN = 64;
    localparam int IMEM_WORDS = 128;
    localparam int DMEM_WORDS = 64;
    localparam int MAX_WRITES = 256;
    localparam int RESET_CYCLES = 10;
    localparam int RUN_TIMEOUT = 400;
    localparam int DRAIN_CYCLES = 20;

    logic               clk;
    logic               arstN;
    logic [`WORD_W-1:0] imAddr, imData, imOffset;
    logic [`WORD_W-1:0] memAddr, memWriteData, memReadData;
    logic               memWrite;
    pipePkg::regWrite_t grfWrite;

    logic [`WORD_W-1:0] imem [IMEM_WORDS];
    logic [`WORD_W-1:0] dmem [DMEM_WORDS];
    logic [`WORD_W-1:0] dmemInit [DMEM_WORDS];
    logic [`WORD_W-1:0] expPc [MAX_WRITES];
    logic [`REG_ADDR_W-1:0] expNum [MAX_WRITES];
    logic [`WORD_W-1:0] expData [MAX_WRITES];
    logic [`WORD_W-1:0] expStAddr [MAX_WRITES];
    logic [`WORD_W-1:0] expStData [MAX_WRITES];

    integer seed;
    int     expCount, waited, runErrors, i;
    int     expStoreCount;
    logic   done;
    int     seenCount, mismatchCount, otherCount;

    always #10 clk = ~clk;

    mipsCore UUT (
        .clk         (clk),
        .arstN       (arstN),
        .imAddr      (imAddr),
        .imData      (imData),
        .memAddr     (memAddr),
        .memWriteData(memWriteData),
        .memWrite    (memWrite),
        .memReadData (memReadData),
        .grfWrite    (grfWrite)
    );

    writebackChecker #(.MAX_WRITES(MAX_WRITES)) wbCheck (
        .clk          (clk),
        .arstN        (arstN),
        .grfWrite     (grfWrite),
        .memWrite     (memWrite),
        .memAddr      (memAddr),
        .memWriteData (memWriteData),
        .done         (done),
        .seenCount    (seenCount),
        .mismatchCount(mismatchCount),
        .otherCount   (otherCount)
    );

    always_comb begin
        imOffset = (imAddr - `RESET_PC) >> 2;
        imData = (imOffset < IMEM_WORDS) ? imem[imOffset[6:0]] : '0;   // nops past the end
    end

    assign memReadData = dmem[memAddr[7:2]];

    always @(posedge clk) begin
        if (arstN && memWrite) begin
            dmem[memAddr[7:2]] <= memWriteData;
        end
    end

    function automatic int randBelow(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [`REG_ADDR_W-1:0] randomReg();
        return `REG_ADDR_W'(randBelow(8));
    endfunction

    function automatic logic [`WORD_W-1:0] rType(logic [5:0] funct, logic [4:0] rs,
                                                 logic [4:0] rt, logic [4:0] rd);
        return {isaPkg::opSpecial, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [`WORD_W-1:0] iType(logic [5:0] op, logic [4:0] rs,
                                                 logic [4:0] rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [`WORD_W-1:0] randomAlu();
        logic [`REG_ADDR_W-1:0] rd, rs, rt;
        logic [15:0] imm;
        rd = randomReg();
        rs = randomReg();
        rt = randomReg();
        imm = 16'(randBelow(65536));
        case (randBelow(4))
            0: return rType(isaPkg::functAddu, rs, rt, rd);
            1: return rType(isaPkg::functSubu, rs, rt, rd);
            2: return iType(isaPkg::opOri, rs, rt, imm);
            default: return iType(isaPkg::opLui, 5'd0, rt, imm);
        endcase
    endfunction

    task automatic fillDataMemory();
        int k;
        for (k = 0; k < DMEM_WORDS; k++) begin
            dmemInit[k] = 32'h5a00_0000 ^ (k * 32'h0004_1011) ^ ~k;
            dmem[k] <= dmemInit[k];
        end
    endtask

    task automatic buildProgram();
        int idx, kind, word;
        logic [`REG_ADDR_W-1:0] ra, rb, rc, rd;
        for (idx = 0; idx < IMEM_WORDS; idx++) begin
            imem[idx] = '0;
        end
        idx = 0;
        while (idx < PROG_LEN) begin
            kind = randBelow(10);
            ra = randomReg();
            rb = randomReg();
            rc = `REG_ADDR_W'(1 + randBelow(7));
            rd = `REG_ADDR_W'(1 + randBelow(7));
            word = randBelow(DMEM_WORDS);
            if (kind == 9 && idx + 4 <= PROG_LEN) begin
                // store data from the previous instruction, load back, then use it
                imem[idx] = iType(isaPkg::opOri, ra, rc, 16'(randBelow(65536)));
                imem[idx + 1] = iType(isaPkg::opSw, 5'd0, rc, 16'(word * 4));
                imem[idx + 2] = iType(isaPkg::opLw, 5'd0, rd, 16'(word * 4));
                imem[idx + 3] = rType(isaPkg::functAddu, rd, ra, randomReg());
                idx += 4;
            end else if (kind == 8 && idx + 2 <= PROG_LEN) begin
                if (randBelow(2) == 0) begin
                    rb = ra;    // always taken
                end
                imem[idx] = iType(isaPkg::opBeq, ra, rb, 16'(1 + randBelow(4)));
                imem[idx + 1] = randomAlu();    // delay slot
                idx += 2;
            end else if (kind == 7) begin
                imem[idx] = iType(isaPkg::opLw, 5'd0, ra, 16'(word * 4));
                idx++;
            end else if (kind == 6) begin
                imem[idx] = iType(isaPkg::opSw, 5'd0, ra, 16'(word * 4));
                idx++;
            end else begin
                imem[idx] = randomAlu();
                idx++;
            end
        end
    endtask

    // ISA-level model with one delay slot
    function automatic int runReference();
        logic [`WORD_W-1:0] regs [`REG_CNT];
        logic [`WORD_W-1:0] mem [DMEM_WORDS];
        logic [`WORD_W-1:0] pc, npc, nextNpc, w, value, addr, sImm, offset;
        logic [5:0]  op, funct;
        logic [4:0]  rs, rt, rd, dest;
        logic [15:0] imm;
        logic        wr;
        int          count, steps, k;
        for (k = 0; k < `REG_CNT; k++) begin
            regs[k] = '0;
        end
        for (k = 0; k < DMEM_WORDS; k++) begin
            mem[k] = dmemInit[k];
        end
        pc = `RESET_PC;
        npc = pc + `PC_STEP;
        count = 0;
        expStoreCount = 0;
        steps = 0;
        offset = 0;
        while (offset < IMEM_WORDS && steps < 4 * IMEM_WORDS) begin
            w = imem[offset[6:0]];
            op = w[31:26];
            rs = w[25:21];
            rt = w[20:16];
            rd = w[15:11];
            funct = w[5:0];
            imm = w[15:0];
            sImm = {{16{imm[15]}}, imm};
            nextNpc = npc + `PC_STEP;
            wr = 1'b0;
            dest = rt;
            value = '0;
            case (op)
                isaPkg::opSpecial: begin
                    dest = rd;
                    wr = (funct == isaPkg::functAddu) || (funct == isaPkg::functSubu);
                    value = (funct == isaPkg::functSubu) ? regs[rs] - regs[rt]
                                                         : regs[rs] + regs[rt];
                end
                isaPkg::opOri: begin
                    wr = 1'b1;
                    value = regs[rs] | {16'h0000, imm};
                end
                isaPkg::opLui: begin
                    wr = 1'b1;
                    value = {imm, 16'h0000};
                end
                isaPkg::opLw: begin
                    addr = regs[rs] + sImm;
                    wr = 1'b1;
                    value = mem[addr[7:2]];
                end
                isaPkg::opSw: begin
                    addr = regs[rs] + sImm;
                    mem[addr[7:2]] = regs[rt];
                    if (expStoreCount < MAX_WRITES) begin
                        expStAddr[expStoreCount] = addr;
                        expStData[expStoreCount] = regs[rt];
                        expStoreCount++;
                    end
                end
                isaPkg::opBeq: begin
                    if (regs[rs] == regs[rt]) begin
                        nextNpc = pc + `PC_STEP + {sImm[29:0], 2'b00};
                    end
                end
                default: ;
            endcase
            if (wr && dest != '0 && count < MAX_WRITES) begin
                regs[dest] = value;
                expPc[count] = pc;
                expNum[count] = dest;
                expData[count] = value;
                count++;
            end
            pc = npc;
            npc = nextNpc;
            offset = (pc - `RESET_PC) >> 2;
            steps++;
        end
        return count;
    endfunction

    initial begin
        seed = 43225;
        clk = 1'b0;
        arstN = 1'b0;
        runErrors = 0;
        fillDataMemory();
        buildProgram();
        expCount = runReference();
        for (i = 0; i < expCount; i++) begin
            wbCheck.addExpected(expPc[i], expNum[i], expData[i]);
        end
        for (i = 0; i < expStoreCount; i++) begin
            wbCheck.addExpectedStore(expStAddr[i], expStData[i]);
        end
        repeat (RESET_CYCLES) @(negedge clk);
        arstN = 1'b1;
        waited = 0;
        while (!done && waited < RUN_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!done) begin
            $display("timeout waiting for writes and stores: saw %0d of %0d writes after %0d cycles",
                     seenCount, expCount, waited);
            runErrors++;
        end else begin
            repeat (DRAIN_CYCLES) @(negedge clk);   // catch extra writes
        end
        $display("error counts: mismatches %0d, other errors %0d",
                 mismatchCount, otherCount + runErrors);
        if (mismatchCount + otherCount + runErrors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: testbench/writebackChecker.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module writebackChecker #(
    parameter int MAX_WRITES = 256,
    parameter int FILL_EDGES = 3
) (
    input  logic               clk,
    input  logic               arstN,
    input  pipePkg::regWrite_t grfWrite,
    input  logic               memWrite,
    input  logic [`WORD_W-1:0] memAddr,
    input  logic [`WORD_W-1:0] memWriteData,
    output logic               done,
    output int                 seenCount,
    output int                 mismatchCount,
    output int                 otherCount
);
    pipePkg::regWrite_t expList [MAX_WRITES];
    logic [`WORD_W-1:0] expStoreAddr [MAX_WRITES];
    logic [`WORD_W-1:0] expStoreData [MAX_WRITES];
    int expCount = 0;
    int seen = 0;
    int expStores = 0;
    int storesSeen = 0;
    int mismatches = 0;
    int others = 0;
    int edgesAfterReset = 0;

    assign done = (seen == expCount) && (storesSeen == expStores);
    assign seenCount = seen;
    assign mismatchCount = mismatches;
    assign otherCount = others;

    task automatic addExpected(input logic [`WORD_W-1:0] wPc,
                               input logic [`REG_ADDR_W-1:0] wNum,
                               input logic [`WORD_W-1:0] wData);
        if (expCount < MAX_WRITES) begin
            expList[expCount] = '{enable: 1'b1, number: wNum, data: wData, pc: wPc};
            expCount++;
        end else begin
            $display("expected write list is full, entry for pc %h dropped", wPc);
            others++;
        end
    endtask

    task automatic addExpectedStore(input logic [`WORD_W-1:0] sAddr,
                                    input logic [`WORD_W-1:0] sData);
        if (expStores < MAX_WRITES) begin
            expStoreAddr[expStores] = sAddr;
            expStoreData[expStores] = sData;
            expStores++;
        end else begin
            $display("expected store list is full, store to %h dropped", sAddr);
            others++;
        end
    endtask

    task automatic checkWrite();
        pipePkg::regWrite_t want;
        if (grfWrite.number == '0) begin
            $display("register 0 written by pc %h at %0t", grfWrite.pc, $time);
            others++;
        end
        if (seen >= expCount) begin
            $display("unexpected extra register write from pc %h at %0t", grfWrite.pc, $time);
            others++;
        end else begin
            want = expList[seen];
            if (grfWrite !== want) begin
                $display("mismatch at %0t: write %0d got pc %h r%0d=%h, expected pc %h r%0d=%h",
                         $time, seen, grfWrite.pc, grfWrite.number, grfWrite.data,
                         want.pc, want.number, want.data);
                mismatches++;
            end
            seen++;
        end
    endtask

    task automatic checkStore();
        if (storesSeen >= expStores) begin
            $display("unexpected extra store to %h at %0t", memAddr, $time);
            others++;
        end else begin
            if (memAddr !== expStoreAddr[storesSeen] ||
                memWriteData !== expStoreData[storesSeen]) begin
                $display("mismatch at %0t: store %0d got [%h]=%h, expected [%h]=%h",
                         $time, storesSeen, memAddr, memWriteData,
                         expStoreAddr[storesSeen], expStoreData[storesSeen]);
                mismatches++;
            end
            storesSeen++;
        end
    endtask

    always @(posedge clk) begin
        if (!arstN || edgesAfterReset < FILL_EDGES) begin
            if (grfWrite.enable || memWrite) begin
                $display("write strobe high during or right after reset at %0t", $time);
                others++;
            end
        end
        if (!arstN) begin
            edgesAfterReset = 0;
        end else begin
            if (edgesAfterReset < FILL_EDGES) begin
                edgesAfterReset++;    // pipeline still filling
            end
            if (grfWrite.enable) begin
                checkWrite();
            end
            if (memWrite) begin
                checkStore();
            end
        end
    end

endmodule

// File: design/mipsCore.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module mipsCore (
    input  logic               clk,
    input  logic               arstN,
    output logic [`WORD_W-1:0] imAddr,
    input  logic [`WORD_W-1:0] imData,
    output logic [`WORD_W-1:0] memAddr,
    output logic [`WORD_W-1:0] memWriteData,
    output logic               memWrite,
    input  logic [`WORD_W-1:0] memReadData,
    output pipePkg::regWrite_t grfWrite
);
    logic               stall, branchTaken;
    logic [`WORD_W-1:0] pc, branchTarget, exFwd, memFwd;
    pipePkg::fwdSrc_e   fwdDRs, fwdDRt, fwdERs, fwdERt, fwdMRt;
    pipePkg::ctrl_t     dCtrl;
    pipePkg::fdStage_t  fdIn, fdQ;
    pipePkg::deStage_t  deIn, deQ;
    pipePkg::emStage_t  emIn, emQ;
    pipePkg::mwStage_t  mwIn, mwQ;

    fetchUnit fetch (
        .clk         (clk),
        .arstN       (arstN),
        .stall       (stall),
        .branchTaken (branchTaken),
        .branchTarget(branchTarget),
        .pc          (pc)
    );

    assign imAddr = pc;
    assign fdIn.pc = pc;
    assign fdIn.instr = imData;

    stageReg #(.payload_t(pipePkg::fdStage_t)) fdReg (
        .clk(clk), .arstN(arstN), .stall(stall), .flush(1'b0), .d(fdIn), .q(fdQ)
    );

    decodeStage decode (
        .clk         (clk),
        .arstN       (arstN),
        .fd          (fdQ),
        .fwdRs       (fwdDRs),
        .fwdRt       (fwdDRt),
        .exFwd       (exFwd),
        .memFwd      (memFwd),
        .wbWrite     (grfWrite),
        .ctrl        (dCtrl),
        .de          (deIn),
        .branchTaken (branchTaken),
        .branchTarget(branchTarget)
    );

    hazardUnit hazard (
        .dCtrl (dCtrl),
        .eCtrl (deQ.ctrl),
        .mCtrl (emQ.ctrl),
        .wCtrl (mwQ.ctrl),
        .dInstr(fdQ.instr),
        .eInstr(deQ.instr),
        .mInstr(emQ.instr),
        .stall (stall),
        .fwdDRs(fwdDRs),
        .fwdDRt(fwdDRt),
        .fwdERs(fwdERs),
        .fwdERt(fwdERt),
        .fwdMRt(fwdMRt)
    );

    stageReg #(.payload_t(pipePkg::deStage_t)) deReg (
        .clk(clk), .arstN(arstN), .stall(1'b0), .flush(stall), .d(deIn), .q(deQ)
    );

    executeStage execute (
        .de    (deQ),
        .fwdRs (fwdERs),
        .fwdRt (fwdERt),
        .memFwd(memFwd),
        .wbFwd (grfWrite.data),
        .em    (emIn),
        .exFwd (exFwd)
    );

    stageReg #(.payload_t(pipePkg::emStage_t)) emReg (
        .clk(clk), .arstN(arstN), .stall(1'b0), .flush(1'b0), .d(emIn), .q(emQ)
    );

    assign memFwd = emQ.aluResult;  // loads never forward from here
    assign memAddr = emQ.aluResult;
    assign memWriteData = (fwdMRt == pipePkg::fwdWb) ? grfWrite.data : emQ.storeData;
    assign memWrite = emQ.ctrl.memWrite;

    assign mwIn.pc = emQ.pc;
    assign mwIn.ctrl = emQ.ctrl;
    assign mwIn.result = emQ.ctrl.memRead ? memReadData : emQ.aluResult;

    stageReg #(.payload_t(pipePkg::mwStage_t)) mwReg (
        .clk(clk), .arstN(arstN), .stall(1'b0), .flush(1'b0), .d(mwIn), .q(mwQ)
    );

    assign grfWrite.enable = mwQ.ctrl.wr;
    assign grfWrite.number = mwQ.ctrl.dest;
    assign grfWrite.data = mwQ.result;
    assign grfWrite.pc = mwQ.pc;

endmodule

// File: design/executeStage.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module executeStage (
    input  pipePkg::deStage_t  de,
    input  pipePkg::fwdSrc_e   fwdRs,
    input  pipePkg::fwdSrc_e   fwdRt,
    input  logic [`WORD_W-1:0] memFwd,
    input  logic [`WORD_W-1:0] wbFwd,
    output pipePkg::emStage_t  em,
    output logic [`WORD_W-1:0] exFwd
);
    logic [`WORD_W-1:0] rsVal, rtVal, opB, luiVal, aluResult;

    assign rsVal = (fwdRs == pipePkg::fwdMem) ? memFwd :
                   (fwdRs == pipePkg::fwdWb)  ? wbFwd : de.rsData;
    assign rtVal = (fwdRt == pipePkg::fwdMem) ? memFwd :
                   (fwdRt == pipePkg::fwdWb)  ? wbFwd : de.rtData;

    assign opB = de.ctrl.immOp ? de.imm : rtVal;
    assign luiVal = {de.imm[`IMM_W-1:0], {`IMM_W{1'b0}}};

    always_comb begin
        case (de.ctrl.aluOp)
            isaPkg::aluSub: aluResult = rsVal - opB;
            isaPkg::aluOr:  aluResult = rsVal | opB;
            isaPkg::aluLui: aluResult = luiVal;
            default:        aluResult = rsVal + opB;
        endcase
    end

    assign exFwd = luiVal;    // only valid when Tnew says so

    always_comb begin
        em.pc = de.pc;
        em.instr = de.instr;
        em.ctrl = de.ctrl;
        em.aluResult = aluResult;
        em.storeData = rtVal;
    end

endmodule

// File: design/hazardUnit.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module hazardUnit (
    input  pipePkg::ctrl_t   dCtrl,
    input  pipePkg::ctrl_t   eCtrl,
    input  pipePkg::ctrl_t   mCtrl,
    input  pipePkg::ctrl_t   wCtrl,
    input  isaPkg::instr_t   dInstr,
    input  isaPkg::instr_t   eInstr,
    input  isaPkg::instr_t   mInstr,
    output logic             stall,
    output pipePkg::fwdSrc_e fwdDRs,
    output pipePkg::fwdSrc_e fwdDRt,
    output pipePkg::fwdSrc_e fwdERs,
    output pipePkg::fwdSrc_e fwdERt,
    output pipePkg::fwdSrc_e fwdMRt
);
    logic [1:0] eTnew, mTnew;

    function automatic logic writes(pipePkg::ctrl_t c, logic [`REG_ADDR_W-1:0] r);
        return c.wr && (c.dest == r);
    endfunction

    // cycles left until the result exists
    assign eTnew = (eCtrl.tNew > 2'd1) ? eCtrl.tNew - 2'd1 : 2'd0;
    assign mTnew = (mCtrl.tNew > 2'd2) ? mCtrl.tNew - 2'd2 : 2'd0;

    function automatic logic late(logic [`REG_ADDR_W-1:0] r, logic [1:0] tUse,
                                  pipePkg::ctrl_t e, pipePkg::ctrl_t m,
                                  logic [1:0] eT, logic [1:0] mT);
        if (writes(e, r)) begin
            return eT > tUse;    // nearest producer decides
        end
        return writes(m, r) && (mT > tUse);
    endfunction

    assign stall = late(dInstr.rs, dCtrl.tUseRs, eCtrl, mCtrl, eTnew, mTnew) ||
                   late(dInstr.rt, dCtrl.tUseRt, eCtrl, mCtrl, eTnew, mTnew);

    function automatic pipePkg::fwdSrc_e pick(logic [`REG_ADDR_W-1:0] r,
                                              pipePkg::ctrl_t near, logic [1:0] nearT,
                                              pipePkg::fwdSrc_e nearSrc,
                                              pipePkg::ctrl_t far, logic [1:0] farT,
                                              pipePkg::fwdSrc_e farSrc);
        if (writes(near, r)) begin
            return (nearT == 2'd0) ? nearSrc : pipePkg::fwdNone;
        end
        if (writes(far, r)) begin
            return (farT == 2'd0) ? farSrc : pipePkg::fwdNone;
        end
        return pipePkg::fwdNone;
    endfunction

    // writeback into decode goes through the register file
    assign fwdDRs = pick(dInstr.rs, eCtrl, eTnew, pipePkg::fwdEx, mCtrl, mTnew, pipePkg::fwdMem);
    assign fwdDRt = pick(dInstr.rt, eCtrl, eTnew, pipePkg::fwdEx, mCtrl, mTnew, pipePkg::fwdMem);
    assign fwdERs = pick(eInstr.rs, mCtrl, mTnew, pipePkg::fwdMem, wCtrl, 2'd0, pipePkg::fwdWb);
    assign fwdERt = pick(eInstr.rt, mCtrl, mTnew, pipePkg::fwdMem, wCtrl, 2'd0, pipePkg::fwdWb);
    assign fwdMRt = writes(wCtrl, mInstr.rt) ? pipePkg::fwdWb : pipePkg::fwdNone;

endmodule

// File: design/decodeStage.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module decodeStage (
    input  logic               clk,
    input  logic               arstN,
    input  pipePkg::fdStage_t  fd,
    input  pipePkg::fwdSrc_e   fwdRs,
    input  pipePkg::fwdSrc_e   fwdRt,
    input  logic [`WORD_W-1:0] exFwd,
    input  logic [`WORD_W-1:0] memFwd,
    input  pipePkg::regWrite_t wbWrite,
    output pipePkg::ctrl_t     ctrl,
    output pipePkg::deStage_t  de,
    output logic               branchTaken,
    output logic [`WORD_W-1:0] branchTarget
);
    logic [`WORD_W-1:0] regs [`REG_CNT];
    logic [`WORD_W-1:0] rsRaw, rtRaw;
    logic [`WORD_W-1:0] rsData, rtData;
    logic [`WORD_W-1:0] immExt;
    logic               zeroExt;
    isaPkg::instr_t     instr;

    assign instr = fd.instr;

    always_comb begin
        ctrl = '0;
        ctrl.tUseRs = 2'd3;    // 3 = source not read
        ctrl.tUseRt = 2'd3;
        zeroExt = 1'b0;
        case (instr.op)
            isaPkg::opSpecial: begin
                case (instr.low.r.funct)
                    isaPkg::functAddu, isaPkg::functSubu: begin
                        ctrl.aluOp = (instr.low.r.funct == isaPkg::functSubu) ?
                                     isaPkg::aluSub : isaPkg::aluAdd;
                        ctrl.dest = instr.low.r.rd;
                        ctrl.wr = 1'b1;
                        ctrl.tUseRs = 2'd1;
                        ctrl.tUseRt = 2'd1;
                        ctrl.tNew = 2'd2;
                    end
                    default: ;     // sll $0 and friends act as nop
                endcase
            end
            isaPkg::opOri: begin
                ctrl.aluOp = isaPkg::aluOr;
                ctrl.immOp = 1'b1;
                ctrl.dest = instr.rt;
                ctrl.wr = 1'b1;
                ctrl.tUseRs = 2'd1;
                ctrl.tNew = 2'd2;
                zeroExt = 1'b1;
            end
            isaPkg::opLui: begin
                ctrl.aluOp = isaPkg::aluLui;
                ctrl.immOp = 1'b1;
                ctrl.dest = instr.rt;
                ctrl.wr = 1'b1;
                ctrl.tNew = 2'd1;    // ready in execute
                zeroExt = 1'b1;
            end
            isaPkg::opLw: begin
                ctrl.immOp = 1'b1;
                ctrl.memRead = 1'b1;
                ctrl.dest = instr.rt;
                ctrl.wr = 1'b1;
                ctrl.tUseRs = 2'd1;
                ctrl.tNew = 2'd3;
            end
            isaPkg::opSw: begin
                ctrl.immOp = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.tUseRs = 2'd1;
                ctrl.tUseRt = 2'd2;  // store data needed in memory
            end
            isaPkg::opBeq: begin
                ctrl.tUseRs = 2'd0;
                ctrl.tUseRt = 2'd0;
            end
            default: ;
        endcase
        if (ctrl.dest == '0) begin
            ctrl.wr = 1'b0;        // $0 stays zero
        end
    end

    assign immExt = zeroExt ? {{(`WORD_W-`IMM_W){1'b0}}, instr.low.imm}
                            : {{(`WORD_W-`IMM_W){instr.low.imm[`IMM_W-1]}}, instr.low.imm};

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            regs <= '{default: '0};
        end else if (wbWrite.enable) begin
            regs[wbWrite.number] <= wbWrite.data;
        end
    end

    // write-before-read
    assign rsRaw = (wbWrite.enable && wbWrite.number == instr.rs) ? wbWrite.data : regs[instr.rs];
    assign rtRaw = (wbWrite.enable && wbWrite.number == instr.rt) ? wbWrite.data : regs[instr.rt];

    assign rsData = (fwdRs == pipePkg::fwdEx)  ? exFwd :
                    (fwdRs == pipePkg::fwdMem) ? memFwd : rsRaw;
    assign rtData = (fwdRt == pipePkg::fwdEx)  ? exFwd :
                    (fwdRt == pipePkg::fwdMem) ? memFwd : rtRaw;

    assign branchTaken = (instr.op == isaPkg::opBeq) && (rsData == rtData);
    assign branchTarget = fd.pc + `PC_STEP + {immExt[`WORD_W-3:0], 2'b00};

    always_comb begin
        de.pc = fd.pc;
        de.instr = instr;
        de.rsData = rsData;
        de.rtData = rtData;
        de.imm = immExt;
        de.ctrl = ctrl;
    end

endmodule

// File: design/stageReg.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module stageReg #(
    parameter type payload_t = logic [`WORD_W-1:0]
) (
    input  logic     clk,
    input  logic     arstN,
    input  logic     stall,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            q <= '0;          // zero payload is a nop
        end else if (flush) begin
            q <= '0;          // bubble
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

// File: design/fetchUnit.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module fetchUnit (
    input  logic               clk,
    input  logic               arstN,
    input  logic               stall,
    input  logic               branchTaken,
    input  logic [`WORD_W-1:0] branchTarget,
    output logic [`WORD_W-1:0] pc
);
    logic [`WORD_W-1:0] nextPc;

    // the branch in decode already sees its delay slot here
    assign nextPc = branchTaken ? branchTarget : pc + `PC_STEP;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= `RESET_PC;
        end else if (!stall) begin
            pc <= nextPc;
        end
    end

endmodule

// File: design/pipePkg.sv
`include "mips_macros.svh"

package pipePkg;

    typedef enum logic [1:0] {fwdNone, fwdEx, fwdMem, fwdWb} fwdSrc_e;

    // T values count stages from decode
    typedef struct packed {
        isaPkg::aluOp_e         aluOp;
        logic                   immOp;
        logic                   memRead;
        logic                   memWrite;
        logic [`REG_ADDR_W-1:0] dest;
        logic                   wr;
        logic [1:0]             tUseRs;
        logic [1:0]             tUseRt;
        logic [1:0]             tNew;
    } ctrl_t;

    typedef struct packed {
        logic [`WORD_W-1:0] pc;
        isaPkg::instr_t     instr;
    } fdStage_t;

    typedef struct packed {
        logic [`WORD_W-1:0] pc;
        isaPkg::instr_t     instr;
        logic [`WORD_W-1:0] rsData;
        logic [`WORD_W-1:0] rtData;
        logic [`WORD_W-1:0] imm;
        ctrl_t              ctrl;
    } deStage_t;

    typedef struct packed {
        logic [`WORD_W-1:0] pc;
        isaPkg::instr_t     instr;   // rt needed for the memory-stage forward
        ctrl_t              ctrl;
        logic [`WORD_W-1:0] aluResult;
        logic [`WORD_W-1:0] storeData;
    } emStage_t;

    typedef struct packed {
        logic [`WORD_W-1:0] pc;
        ctrl_t              ctrl;
        logic [`WORD_W-1:0] result;
    } mwStage_t;

    typedef struct packed {
        logic                   enable;
        logic [`REG_ADDR_W-1:0] number;
        logic [`WORD_W-1:0]     data;
        logic [`WORD_W-1:0]     pc;
    } regWrite_t;

endpackage

// File: design/isaPkg.sv
`include "mips_macros.svh"

package isaPkg;

    typedef enum logic [`OP_W-1:0] {
        opSpecial = 6'h00,
        opBeq     = 6'h04,
        opOri     = 6'h0d,
        opLui     = 6'h0f,
        opLw      = 6'h23,
        opSw      = 6'h2b
    } opcode_e;

    typedef enum logic [`FUNCT_W-1:0] {
        functAddu = 6'h21,
        functSubu = 6'h23
    } funct_e;

    // R-type low half
    typedef struct packed {
        logic [`REG_ADDR_W-1:0] rd;
        logic [`SHAMT_W-1:0]    shamt;
        funct_e                 funct;
    } rLow_t;

    typedef union packed {
        rLow_t              r;
        logic [`IMM_W-1:0]  imm;
    } low_t;

    typedef struct packed {
        opcode_e                op;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        low_t                   low;
    } instr_t;

    typedef enum logic [1:0] {aluAdd, aluSub, aluOr, aluLui} aluOp_e;

endpackage

// File: design/mips_macros.svh
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

`define WORD_W      32
`define REG_CNT     32
`define REG_ADDR_W  5

`define RESET_PC    32'h0000_3000
`define PC_STEP     32'd4

// instruction field widths
`define OP_W        6
`define SHAMT_W     5
`define FUNCT_W     6
`define IMM_W       16

`endif
